// File: Makefile
TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: hdl/dcache_array_if.sv
// array command interface
`timescale 1ns/10ps
`default_nettype none

interface dcache_array_if #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
);
    import dcache_pkg::*;

    // commands from the controller, one cycle each
    logic [num_ways-1:0] data_we;
    logic                refill;
    logic                inval;
    logic                touch;
    logic                take_return;

    // lookup result of the buffered set
    logic [num_ways-1:0] hit;
    logic                victim;

    // tag must keep at least one bit above index and offset
    if (index_width + offset_width + 2 >= 32) begin : g_width_check
        $error("index and offset widths leave no tag bits");
    end

    modport ctrl (output data_we, refill, inval, touch, take_return, input hit, victim);
    modport ways (input data_we, refill, inval, touch, take_return, output hit, victim);

endinterface

`default_nettype wire

// File: hdl/dcache_ctrl.sv
// data cache controller
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  valid,
    input  dcache_pkg::req_kind_e kind_new,
    input  dcache_pkg::req_kind_e kind_buf,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    output logic                  ready,
    output logic                  stall,
    output logic                  load_buf,
    output logic                  rdata_valid,
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [1:0]            mem_size,
    dcache_array_if.ctrl          arr
);
    import dcache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    ctrl_state_e accept_state;
    logic        any_hit;

    assign any_hit = |arr.hit;

    // where a new request goes once the current one is done
    always_comb begin
        if (!valid) begin
            accept_state = st_idle;
        end else if (kind_new == req_inval) begin
            accept_state = st_inval;
        end else begin
            accept_state = st_lookup;
        end
    end

    ////////////////////
    // state register

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                next_state = accept_state;
            end
            st_lookup: begin
                if (kind_buf == req_write) begin
                    next_state = any_hit ? st_hit_w : st_miss_w;
                end else begin
                    // read hit lets the next request in right away
                    next_state = any_hit ? accept_state : st_miss_r;
                end
            end
            st_inval: begin
                next_state = st_idle;
            end
            st_miss_r: begin
                if (mem_addr_ok) begin
                    next_state = st_miss_r_wait;
                end
            end
            st_miss_r_wait: begin
                if (mem_data_ok) begin
                    next_state = accept_state;
                end
            end
            st_hit_w, st_miss_w: begin
                if (mem_addr_ok) begin
                    next_state = accept_state;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    ////////////////////
    // outputs and array commands

    always_comb begin
        ready           = 1'b0;
        rdata_valid     = 1'b0;
        mem_req         = 1'b0;
        mem_wr          = 1'b0;
        arr.data_we     = '0;
        arr.refill      = 1'b0;
        arr.inval       = 1'b0;
        arr.touch       = 1'b0;
        arr.take_return = 1'b0;
        case (state)
            st_idle: begin
                ready = 1'b1;
            end
            st_lookup: begin
                arr.touch = any_hit;
                if (next_state == st_hit_w) begin
                    // merge lands on the edge closing lookup
                    arr.data_we = arr.hit;
                end else if (any_hit) begin
                    ready       = 1'b1;
                    rdata_valid = 1'b1;
                end
            end
            st_inval: begin
                arr.inval = 1'b1;
            end
            st_miss_r: begin
                mem_req = 1'b1;
            end
            st_miss_r_wait: begin
                if (next_state != st_miss_r_wait) begin
                    ready                   = 1'b1;
                    rdata_valid             = 1'b1;
                    arr.refill              = 1'b1;
                    arr.take_return         = 1'b1;
                    arr.touch               = 1'b1;
                    arr.data_we[arr.victim] = 1'b1;
                end
            end
            st_hit_w, st_miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                ready   = mem_addr_ok;
            end
            default: begin
                ready = 1'b0;
            end
        endcase
    end

    assign stall    = ~ready;
    assign load_buf = ready & valid;
    assign mem_size = mem_size_word;

    ////////////////////
    // checks

    // a line lives in one way only
    a_one_hit: assert property (@(posedge clk) disable iff (!rstn)
        !(arr.hit[0] && arr.hit[1]));

    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req);

    // a read miss keeps the pipeline waiting until the line returns
    a_no_ready_miss: assert property (@(posedge clk) disable iff (!rstn)
        state == st_miss_r |=> !ready || mem_data_ok);

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
// data cache shared types
`default_nettype none

package dcache_pkg;

    ////////////////////
    // data types

    // one data word on the pipeline and memory ports
    typedef logic [31:0] word_t;

    // byte write enables for one word
    typedef logic [3:0] strb_t;

    ////////////////////
    // geometry

    // one lru bit per set only works for two ways
    localparam int num_ways = 2;

    // memory access size code for a full word
    localparam logic [1:0] mem_size_word = 2'd2;

    ////////////////////
    // encodings

    typedef enum logic [1:0] {
        req_read  = 2'd0,
        req_write = 2'd1,
        req_inval = 2'd2
    } req_kind_e;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_lookup      = 3'd1,
        st_inval       = 3'd2,
        st_miss_r      = 3'd3,
        st_miss_r_wait = 3'd4,
        st_hit_w       = 3'd5,
        st_miss_w      = 3'd6
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/dcache_req_buf.sv
// request buffer
`timescale 1ns/10ps
`default_nettype none

module dcache_req_buf #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  load,
    input  dcache_pkg::req_kind_e kind_in,
    input  dcache_pkg::word_t     addr_in,
    input  dcache_pkg::word_t     wdata_in,
    input  dcache_pkg::strb_t     wstrb_in,
    output dcache_pkg::req_kind_e kind,
    output dcache_pkg::word_t     addr,
    output dcache_pkg::word_t     wdata,
    output dcache_pkg::strb_t     wstrb,
    output logic [index_width-1:0] new_index,
    output dcache_pkg::word_t     mem_addr
);
    import dcache_pkg::*;

    // lowest address bit above the line offset
    localparam int line_lsb = offset_width + 2;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kind <= req_read;
        end else if (load) begin
            kind <= kind_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr  <= addr_in;
            wdata <= wdata_in;
            wstrb <= wstrb_in;
        end
    end

    // set of the incoming request, for the registered array read
    assign new_index = addr_in[line_lsb +: index_width];

    // writes go out per word, read misses fetch the whole line
    assign mem_addr = (kind == req_write) ? addr : (addr & ~word_t'((1 << line_lsb) - 1));

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
// data cache top level
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    // pipeline side
    input  logic                            valid,
    input  dcache_pkg::req_kind_e           kind,
    input  dcache_pkg::word_t               addr,
    input  dcache_pkg::word_t               wdata,
    input  dcache_pkg::strb_t               wstrb,
    output logic                            ready,
    output logic                            stall,
    output logic                            rdata_valid,
    output dcache_pkg::word_t               rdata,
    // memory side
    output logic                            mem_req,
    output logic                            mem_wr,
    output logic [1:0]                      mem_size,
    output dcache_pkg::word_t               mem_addr,
    output dcache_pkg::word_t               mem_wdata,
    output dcache_pkg::strb_t               mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [(32 << offset_width)-1:0] mem_rline
);
    import dcache_pkg::*;

    req_kind_e              kind_buf;
    word_t                  addr_buf;
    logic [index_width-1:0] new_index;
    logic                   load_buf;

    dcache_array_if #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) arr_if ();

    // buffered write data and strobes feed both the ways and memory
    dcache_req_buf #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .load      (load_buf),
        .kind_in   (kind),
        .addr_in   (addr),
        .wdata_in  (wdata),
        .wstrb_in  (wstrb),
        .kind      (kind_buf),
        .addr      (addr_buf),
        .wdata     (mem_wdata),
        .wstrb     (mem_wstrb),
        .new_index (new_index),
        .mem_addr  (mem_addr)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .kind_new    (kind),
        .kind_buf    (kind_buf),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .ready       (ready),
        .stall       (stall),
        .load_buf    (load_buf),
        .rdata_valid (rdata_valid),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .arr         (arr_if.ctrl)
    );

    dcache_ways #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_ways (
        .clk       (clk),
        .rstn      (rstn),
        .addr      (addr_buf),
        .new_index (new_index),
        .wdata     (mem_wdata),
        .wstrb     (mem_wstrb),
        .mem_rline (mem_rline),
        .rdata     (rdata),
        .arr       (arr_if.ways)
    );

endmodule

`default_nettype wire

// File: hdl/dcache_ways.sv
// two-way tag and data storage
`timescale 1ns/10ps
`default_nettype none

module dcache_ways #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  dcache_pkg::word_t               addr,
    input  logic [index_width-1:0]          new_index,
    input  dcache_pkg::word_t               wdata,
    input  dcache_pkg::strb_t               wstrb,
    input  logic [(32 << offset_width)-1:0] mem_rline,
    output dcache_pkg::word_t               rdata,
    dcache_array_if.ways                    arr
);
    import dcache_pkg::*;

    localparam int line_width = 32 << offset_width;
    localparam int tag_width  = 32 - index_width - offset_width - 2;
    localparam int num_sets   = 1 << index_width;

    logic [tag_width-1:0]  tag_mem  [num_ways][num_sets];
    logic [line_width-1:0] line_mem [num_ways][num_sets];
    logic [num_sets-1:0]   valid    [num_ways];
    // per set, the way used last
    logic [num_sets-1:0]   mru;

    logic [line_width-1:0] rd_line [num_ways];
    logic [line_width-1:0] wr_line [num_ways];
    logic [line_width-1:0] sel_line;

    logic [offset_width-1:0] offset;
    logic [index_width-1:0]  index;
    logic [tag_width-1:0]    tag;
    logic                    touch_way;

    assign offset = addr[2 +: offset_width];
    assign index  = addr[offset_width+2 +: index_width];
    assign tag    = addr[31 -: tag_width];

    ////////////////////
    // lookup

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            arr.hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    // empty ways fill first, way 0 before way 1
    always_comb begin
        if (!valid[0][index]) begin
            arr.victim = 1'b0;
        end else if (!valid[1][index]) begin
            arr.victim = 1'b1;
        end else begin
            arr.victim = ~mru[index];
        end
    end

    always_comb begin
        if (arr.take_return) begin
            sel_line = mem_rline;
        end else if (arr.hit[1]) begin
            sel_line = rd_line[1];
        end else begin
            sel_line = rd_line[0];
        end
        rdata = sel_line[offset*32 +: 32];
    end

    ////////////////////
    // update

    // store word merged under strobes, or the whole refill line
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            wr_line[w] = rd_line[w];
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    wr_line[w][offset*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            if (arr.refill) begin
                wr_line[w] = mem_rline;
            end
        end
    end

    // registered read at the incoming set, forwarding a same-edge write
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (arr.data_we[w]) begin
                line_mem[w][index] <= wr_line[w];
                tag_mem[w][index]  <= tag;
            end
            if (arr.data_we[w] && new_index == index) begin
                rd_line[w] <= wr_line[w];
            end else begin
                rd_line[w] <= line_mem[w][new_index];
            end
        end
    end

    assign touch_way = arr.refill ? arr.victim : arr.hit[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < num_ways; w++) begin
                valid[w] <= '0;
            end
            mru <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (arr.inval) begin
                    valid[w][index] <= 1'b0;
                end else if (arr.refill && arr.data_we[w]) begin
                    valid[w][index] <= 1'b1;
                end
            end
            if (arr.touch) begin
                mru[index] <= touch_way;
            end
        end
    end

    a_refill_inval: assert property (@(posedge clk) disable iff (!rstn)
        !(arr.refill && arr.inval));

endmodule

`default_nettype wire

// File: sim.f
hdl/dcache_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_req_buf.sv
hdl/dcache_ctrl.sv
hdl/dcache_ways.sv
hdl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// File: testbench/tb_dcache.sv
// data cache testbench
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int line_width   = 32 << offset_width;
    localparam int tag_lsb      = index_width + offset_width + 2;
    localparam int num_sets     = 1 << index_width;
    localparam int addr_bits    = 12;

    typedef struct packed {
        req_kind_e kind;
        word_t     addr;
        word_t     wdata;
        strb_t     wstrb;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  valid;
    req_kind_e             kind;
    word_t                 addr;
    word_t                 wdata;
    strb_t                 wstrb;
    logic                  ready;
    logic                  stall;
    logic                  rdata_valid;
    word_t                 rdata;
    logic                  mem_req;
    logic                  mem_wr;
    logic [1:0]            mem_size;
    word_t                 mem_addr;
    word_t                 mem_wdata;
    strb_t                 mem_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [line_width-1:0] mem_rline;
    int                    rd_count;
    int                    wr_count;

    // stimulus and shadow model of memory, tags and lru
    row_t        rows [$];
    word_t       shadow_mem [1 << addr_bits];
    logic        sh_valid [num_ways][num_sets];
    int unsigned sh_tag [num_ways][num_sets];
    logic        sh_mru [num_sets];
    int          exp_reads = 0;
    int          exp_writes = 0;
    int          word_errors = 0;
    int          count_errors = 0;
    int          flag_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;

    dcache_top #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dut (.*);

    tb_mem_model #(
        .offset_width (offset_width),
        .addr_bits    (addr_bits)
    ) mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the cache stopped responding after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // helpers

    function automatic word_t fill_word(input int unsigned byte_addr);
        return (byte_addr * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ (byte_addr >> 3);
    endfunction

    // empty way 0 first, then empty way 1, else the older way
    function automatic int victim_of(input int set);
        if (!sh_valid[0][set]) begin
            return 0;
        end
        if (!sh_valid[1][set]) begin
            return 1;
        end
        return sh_mru[set] ? 0 : 1;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            count_errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input req_kind_e k, input word_t a, input word_t d, input strb_t s);
        rows.push_back({k, a, d, s});
    endtask

    task automatic apply_row(input row_t r);
        int                   set;
        int unsigned          tag;
        int                   way;
        logic [addr_bits-1:0] widx;
        set  = int'(r.addr[tag_lsb-1 -: index_width]);
        tag  = r.addr >> tag_lsb;
        widx = r.addr[2 +: addr_bits];
        way  = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[w][set] && sh_tag[w][set] == tag) begin
                way = w;
            end
        end
        while (!ready) begin
            @(negedge clk);
        end
        valid = 1'b1;
        kind  = r.kind;
        addr  = r.addr;
        wdata = r.wdata;
        wstrb = r.wstrb;
        @(negedge clk);
        valid = 1'b0;
        case (r.kind)
            req_read: begin
                // miss refills the victim way
                if (way < 0) begin
                    way = victim_of(set);
                    exp_reads++;
                    sh_valid[way][set] = 1'b1;
                    sh_tag[way][set]   = tag;
                end
                sh_mru[set] = (way == 1);
                while (!rdata_valid) begin
                    @(negedge clk);
                end
                check_word(rdata, shadow_mem[widx], "read data");
                check_count(rd_count, exp_reads, "memory reads");
                check_count(wr_count, exp_writes, "memory writes");
            end
            req_write: begin
                for (int b = 0; b < 4; b++) begin
                    if (r.wstrb[b]) begin
                        shadow_mem[widx][b*8 +: 8] = r.wdata[b*8 +: 8];
                    end
                end
                if (way >= 0) begin
                    sh_mru[set] = (way == 1);
                end
                exp_writes++;
            end
            default: begin
                sh_valid[0][set] = 1'b0;
                sh_valid[1][set] = 1'b0;
            end
        endcase
    endtask

    task automatic load_table();
        // read miss then hits in set 0, strobed write hit
        add_row(req_read,  32'h0000_0104, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_010c, 32'h0, 4'h0);
        add_row(req_write, 32'h0000_0108, 32'hdead_beef, 4'b0101);
        add_row(req_read,  32'h0000_0108, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0100, 32'h0, 4'h0);
        // write miss, no allocate
        add_row(req_write, 32'h0000_0224, 32'h1234_5678, 4'b1111);
        add_row(req_read,  32'h0000_0224, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0228, 32'h0, 4'h0);
        // lru in set 3 as A B A C A B
        add_row(req_read,  32'h0000_0034, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0134, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0038, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0234, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_003c, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0130, 32'h0, 4'h0);
        // fill both ways of set 0, then invalidate it
        add_row(req_read,  32'h0000_0200, 32'h0, 4'h0);
        add_row(req_inval, 32'h0000_0100, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0104, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0208, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_0108, 32'h0, 4'h0);
        // mixed traffic in set 5
        add_row(req_read,  32'h0000_1f54, 32'h0, 4'h0);
        add_row(req_write, 32'h0000_2f58, 32'hff00_ff00, 4'b1100);
        add_row(req_read,  32'h0000_2f58, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_3f5c, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_1f50, 32'h0, 4'h0);
        add_row(req_write, 32'h0000_1f54, 32'ha5a5_a5a5, 4'b0011);
        add_row(req_read,  32'h0000_1f54, 32'h0, 4'h0);
        add_row(req_inval, 32'h0000_0050, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_3f50, 32'h0, 4'h0);
        add_row(req_read,  32'h0000_1f54, 32'h0, 4'h0);
    endtask

    ////////////////////
    // main sequence

    initial begin
        rstn  = 1'b0;
        valid = 1'b0;
        kind  = req_read;
        addr  = '0;
        wdata = '0;
        wstrb = '0;
        load_table();
        // reset plus ten cycles per row
        cycle_limit = rows.size() * 10 + 10;
        for (int i = 0; i < (1 << addr_bits); i++) begin
            shadow_mem[i]       = fill_word(i * 4);
            mem_model.words[i]  = shadow_mem[i];
        end
        for (int s = 0; s < num_sets; s++) begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_mru[s]      = 1'b0;
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_flag(ready, 1'b1, "ready after reset");
        check_flag(stall, 1'b0, "stall after reset");
        check_flag(mem_req, 1'b0, "mem_req after reset");
        check_flag(rdata_valid, 1'b0, "rdata_valid after reset");
        check_count(int'(mem_size), 2, "memory access size");
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        while (!ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_count(rd_count, exp_reads, "final memory reads");
        check_count(wr_count, exp_writes, "final memory writes");
        $display("errors: data %0d, count %0d, flag %0d", word_errors, count_errors, flag_errors);
        if (word_errors + count_errors + flag_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
// memory model with random delays
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter int offset_width = 2,
    parameter int addr_bits    = 12
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            mem_req,
    input  logic                            mem_wr,
    input  dcache_pkg::word_t               mem_addr,
    input  dcache_pkg::word_t               mem_wdata,
    input  dcache_pkg::strb_t               mem_wstrb,
    output logic                            mem_addr_ok,
    output logic                            mem_data_ok,
    output logic [(32 << offset_width)-1:0] mem_rline,
    output int                              rd_count,
    output int                              wr_count
);
    import dcache_pkg::*;

    localparam int words_per_line = 1 << offset_width;

    word_t                words [1 << addr_bits];
    logic [31:0]          seed;
    logic [31:0]          seed_next;
    logic [1:0]           a_cnt;
    logic [1:0]           d_cnt;
    logic                 a_busy;
    logic                 d_busy;
    logic [addr_bits-1:0] rd_base;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign seed_next = lcg_next(seed);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seed        <= 32'd54;
            a_cnt       <= '0;
            d_cnt       <= '0;
            a_busy      <= 1'b0;
            d_busy      <= 1'b0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rline   <= '0;
            rd_base     <= '0;
            rd_count    <= 0;
            wr_count    <= 0;
        end else begin
            mem_data_ok <= 1'b0;
            // address phase, 0 to 3 extra cycles before addr_ok
            if (mem_req && mem_addr_ok) begin
                mem_addr_ok <= 1'b0;
                if (mem_wr) begin
                    wr_count <= wr_count + 1;
                end else begin
                    rd_count <= rd_count + 1;
                    rd_base  <= mem_addr[2 +: addr_bits];
                    d_busy   <= 1'b1;
                    d_cnt    <= seed_next[17:16];
                    seed     <= seed_next;
                end
            end else if (mem_req && !a_busy) begin
                a_busy <= 1'b1;
                a_cnt  <= seed_next[17:16];
                seed   <= seed_next;
            end else if (a_busy && a_cnt != 2'd0) begin
                a_cnt <= a_cnt - 2'd1;
            end else if (a_busy) begin
                a_busy      <= 1'b0;
                mem_addr_ok <= 1'b1;
            end
            // data phase, whole line in one beat
            if (d_busy && d_cnt != 2'd0) begin
                d_cnt <= d_cnt - 2'd1;
            end else if (d_busy) begin
                d_busy      <= 1'b0;
                mem_data_ok <= 1'b1;
                for (int i = 0; i < words_per_line; i++) begin
                    mem_rline[i*32 +: 32] <= words[rd_base + addr_bits'(i)];
                end
            end
        end
    end

    // posted writes land when addr_ok is taken
    always @(posedge clk) begin
        if (rstn && mem_req && mem_wr && mem_addr_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb[b]) begin
                    words[mem_addr[2 +: addr_bits]][b*8 +: 8] = mem_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire
